// ==== hdl/alloc_settings.svh ====
`ifndef ALLOC_SETTINGS_SVH
`define ALLOC_SETTINGS_SVH

// ----------------------------------------------------
// Router port counts
// ----------------------------------------------------

// Input side, one requester per VC group
`define ALLOC_N 4

// Output side, one resource per crossbar output
`define ALLOC_M 4

// Matrices are sized from these two counts in alloc_pkg
// Input-major for requests, output-major for the output stage

`endif

// ==== hdl/alloc_pkg.sv ====
`include "alloc_settings.svh"

package alloc_pkg;

  // ----------------------------------------------------
  // Row and column vectors
  // ----------------------------------------------------

  // One input's view, bit j set means output j wanted or granted
  typedef logic [0:`ALLOC_M-1] in_req_t;

  // One output's view, bit i set means input i wants or holds it
  typedef logic [0:`ALLOC_N-1] out_req_t;

  // ----------------------------------------------------
  // Full matrices
  // ----------------------------------------------------

  // Input-major, row i is input i
  typedef in_req_t [0:`ALLOC_N-1] req_mat_t;

  // Output-major, row j is output j
  typedef out_req_t [0:`ALLOC_M-1] gnt_mat_t;

  // Index 0 sits at the left of each packed row
  // so a hex dump reads input 0 / output 0 first

endpackage

// ==== hdl/rr_arbiter.sv ====
`timescale 1ns/1ns

module rr_arbiter #(
  parameter int WIDTH = 4  // Requester count
) (
  input  logic             clk,
  input  logic             i_rst,
  input  logic             i_ce,       // Pointer update enable
  input  logic [0:WIDTH-1] i_request,  // One bit per requester
  output logic [0:WIDTH-1] o_grant     // One-hot or zero
);

  // Pointer needs at least one bit, even for a single requester
  localparam int PTR_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(WIDTH - 1);

  logic [PTR_W-1:0] ptr_q;      // Highest priority index
  logic [PTR_W-1:0] win_idx;    // Index of this cycle's winner
  logic             win_found;  // Any request seen

  // ----------------------------------------------------
  // Circular priority search
  // ----------------------------------------------------

  // Walk upward from the pointer, wrap past the top
  // First set request wins
  always_comb begin : search
    int idx;
    idx       = 0;
    win_found = 1'b0;
    win_idx   = '0;
    for (int off = 0; off < WIDTH; off++) begin
      idx = int'(ptr_q) + off;
      if (idx >= WIDTH) begin
        idx = idx - WIDTH;  // Wrap around
      end
      if (!win_found && i_request[idx]) begin
        win_found = 1'b1;
        win_idx   = PTR_W'(idx);
      end
    end
  end

  // ----------------------------------------------------
  // Grant decode
  // ----------------------------------------------------

  always_comb begin
    o_grant = '0;
    if (win_found) begin
      o_grant[win_idx] = 1'b1;  // Only the winner
    end
  end

  // ----------------------------------------------------
  // Pointer update
  // ----------------------------------------------------

  // Moves just past the winner, so the winner drops to lowest priority
  // Holds with no request or with the enable low
  always_ff @(posedge clk) begin
    if (i_rst) begin
      ptr_q <= '0;
    end else if (i_ce && win_found) begin
      if (win_idx == LAST_IDX) begin
        ptr_q <= '0;  // Wrap to index 0
      end else begin
        ptr_q <= win_idx + PTR_W'(1);
      end
    end
  end

  // Every requester that stays asserted is served within WIDTH
  // enabled grants, since the pointer can only pass it by granting it

endmodule

// ==== hdl/input_first_allocator.sv ====
`timescale 1ns/1ns

`include "alloc_settings.svh"

module input_first_allocator #(
  parameter int N = `ALLOC_N,  // Inputs
  parameter int M = `ALLOC_M   // Outputs
) (
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_ce,         // Arbiter pointer update
  input  alloc_pkg::req_mat_t i_request,  // N rows of M bits
  output alloc_pkg::gnt_mat_t o_out_grant,  // M rows of N bits
  output alloc_pkg::req_mat_t o_in_grant    // Same grants, input-major
);

  import alloc_pkg::*;

  req_mat_t in_stage_gnt;   // One output picked per input
  gnt_mat_t out_stage_req;  // Input stage result, per output

  // ----------------------------------------------------
  // Input stage
  // ----------------------------------------------------

  // Each input picks one of its requested outputs
  // Pointer moves on its own grant, whether or not the
  // output stage later accepts it
  for (genvar gi = 0; gi < N; gi++) begin : g_in_arb
    rr_arbiter #(
      .WIDTH(M)
    ) in_arb_i (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_ce     (i_ce),
      .i_request(i_request[gi]),
      .o_grant  (in_stage_gnt[gi])
    );
  end

  // Rows become columns for the output stage
  always_comb begin
    out_stage_req = '0;
    for (int o_idx = 0; o_idx < M; o_idx++) begin
      for (int i_idx = 0; i_idx < N; i_idx++) begin
        out_stage_req[o_idx][i_idx] = in_stage_gnt[i_idx][o_idx];
      end
    end
  end

  // ----------------------------------------------------
  // Output stage
  // ----------------------------------------------------

  // Each output keeps one of the inputs that chose it
  for (genvar go = 0; go < M; go++) begin : g_out_arb
    rr_arbiter #(
      .WIDTH(N)
    ) out_arb_i (
      .clk      (clk),
      .i_rst    (i_rst),
      .i_ce     (i_ce),
      .i_request(out_stage_req[go]),
      .o_grant  (o_out_grant[go])
    );
  end

  // Back to input-major so each input sees its own grant row
  always_comb begin
    o_in_grant = '0;
    for (int i_idx = 0; i_idx < N; i_idx++) begin
      for (int o_idx = 0; o_idx < M; o_idx++) begin
        o_in_grant[i_idx][o_idx] = o_out_grant[o_idx][i_idx];
      end
    end
  end

  // Input stage leaves at most one bit per row, output stage at most
  // one bit per column, so the result is a valid matching

endmodule

// ==== hdl/switch_alloc_top.sv ====
`timescale 1ns/1ns

`include "alloc_settings.svh"

module switch_alloc_top (
  input  logic                clk,
  input  logic                i_rst,
  input  logic                i_req_valid,    // One-cycle strobe
  input  alloc_pkg::req_mat_t i_request,      // Input-major request matrix
  output logic                o_grant_valid,  // One-cycle strobe
  output alloc_pkg::gnt_mat_t o_out_grant,    // Output-major grants
  output alloc_pkg::req_mat_t o_in_grant      // Input-major grants
);

  import alloc_pkg::*;

  // Capture stage
  logic     cap_valid_q;  // Request held this cycle
  req_mat_t cap_req_q;    // Held request matrix
  req_mat_t alloc_req;    // What the allocator sees

  // Allocator result, combinational
  gnt_mat_t alloc_out_gnt;
  req_mat_t alloc_in_gnt;

  // Grant stage
  logic     gnt_valid_q;
  gnt_mat_t gnt_out_q;
  req_mat_t gnt_in_q;

  // ----------------------------------------------------
  // Request capture
  // ----------------------------------------------------

  always_ff @(posedge clk) begin
    if (i_rst) begin
      cap_valid_q <= 1'b0;
    end else begin
      cap_valid_q <= i_req_valid;  // Follows the strobe by one cycle
    end
  end

  // Matrix loads only on a strobe
  always_ff @(posedge clk) begin
    if (i_req_valid) begin
      cap_req_q <= i_request;
    end
  end

  // Stale matrix never reaches the arbiters
  assign alloc_req = cap_valid_q ? cap_req_q : '0;

  // ----------------------------------------------------
  // Allocator
  // ----------------------------------------------------

  // Pointers advance only in capture-valid cycles
  input_first_allocator #(
    .N(`ALLOC_N),
    .M(`ALLOC_M)
  ) alloc_i (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_ce       (cap_valid_q),
    .i_request  (alloc_req),
    .o_out_grant(alloc_out_gnt),
    .o_in_grant (alloc_in_gnt)
  );

  // ----------------------------------------------------
  // Grant register
  // ----------------------------------------------------

  always_ff @(posedge clk) begin
    if (i_rst) begin
      gnt_valid_q <= 1'b0;
    end else begin
      gnt_valid_q <= cap_valid_q;  // Two cycles after i_req_valid
    end
  end

  // Payload loads only with a fresh result
  always_ff @(posedge clk) begin
    if (cap_valid_q) begin
      gnt_out_q <= alloc_out_gnt;
      gnt_in_q  <= alloc_in_gnt;
    end
  end

  // ----------------------------------------------------
  // Outputs
  // ----------------------------------------------------

  assign o_grant_valid = gnt_valid_q;

  // Zero whenever no result is presented, including after reset
  assign o_out_grant = gnt_valid_q ? gnt_out_q : '0;
  assign o_in_grant  = gnt_valid_q ? gnt_in_q  : '0;

  // Back-to-back strobes keep both stages busy, one allocation
  // in capture and the previous one in the grant register

endmodule

// ==== dv/switch_alloc_props.sv ====
`timescale 1ns/1ns

`include "alloc_settings.svh"

module switch_alloc_props (
  input logic                clk,
  input logic                i_rst,
  input logic                i_req_valid,
  input alloc_pkg::req_mat_t i_request,      // Strobed request, input-major
  input logic                i_grant_valid,
  input alloc_pkg::gnt_mat_t i_out_grant,    // Output-major grants
  input alloc_pkg::req_mat_t i_in_grant      // Input-major grants
);

  localparam int NM = `ALLOC_N * `ALLOC_M;

  // Flat views for whole-matrix compares
  logic [NM-1:0] req_flat;
  logic [NM-1:0] in_flat;
  logic [NM-1:0] out_flat;

  assign req_flat = i_request;
  assign in_flat  = i_in_grant;
  assign out_flat = i_out_grant;

  // --------------------------------------------------
  // Matching shape
  // --------------------------------------------------

  // One output per input at most
  for (genvar gi = 0; gi < `ALLOC_N; gi++) begin : g_in_row
    a_in_row: assert property (@(posedge clk) disable iff (i_rst)
      $onehot0(i_in_grant[gi]))
      else $error("input %0d holds more than one grant", gi);
  end

  // One input per output at most
  for (genvar go = 0; go < `ALLOC_M; go++) begin : g_out_row
    a_out_row: assert property (@(posedge clk) disable iff (i_rst)
      $onehot0(i_out_grant[go]))
      else $error("output %0d granted to more than one input", go);
  end

  // --------------------------------------------------
  // Grants against the request and the strobes
  // --------------------------------------------------

  // Request seen two edges back is the one that was captured
  a_covered: assert property (@(posedge clk) disable iff (i_rst)
    i_grant_valid |-> ((in_flat & ~$past(req_flat, 2)) == '0))
    else $error("grant bit set without a matching request bit");

  a_zero_idle: assert property (@(posedge clk) disable iff (i_rst)
    !i_grant_valid |-> (in_flat == '0 && out_flat == '0))
    else $error("grant outputs not zero while grant valid is low");

  a_lat_fwd: assert property (@(posedge clk) disable iff (i_rst)
    $past(i_req_valid, 2) |-> i_grant_valid)
    else $error("request strobe not followed by grant valid two cycles later");

  a_lat_back: assert property (@(posedge clk) disable iff (i_rst)
    i_grant_valid |-> $past(i_req_valid, 2))
    else $error("grant valid without a request strobe two cycles earlier");

endmodule

bind switch_alloc_top switch_alloc_props props_i (
  .clk          (clk),
  .i_rst        (i_rst),
  .i_req_valid  (i_req_valid),
  .i_request    (i_request),
  .i_grant_valid(o_grant_valid),
  .i_out_grant  (o_out_grant),
  .i_in_grant   (o_in_grant)
);

// ==== dv/switch_alloc_tb.sv ====
`timescale 1ns/1ns

`include "alloc_settings.svh"

module switch_alloc_tb;

  import alloc_pkg::*;

  localparam int N            = `ALLOC_N;
  localparam int M            = `ALLOC_M;
  localparam int NM           = N * M;
  localparam int SEED         = 75;
  localparam int RESET_CYCLES = 5;

  // Worst-case length of each test in cycles, drain included
  localparam int T1_CYCLES   = 10 + 1 + 6 + 8;
  localparam int T2_ROUNDS   = 8;
  localparam int T2_CYCLES   = 3 * T2_ROUNDS + 8;
  localparam int T3_ROUNDS   = 3 * N;
  localparam int T3_CYCLES   = 3 * T3_ROUNDS + 8;
  localparam int T4_STROBES  = 300;
  localparam int T4_MAX_GAP  = 3;
  localparam int T4_CYCLES   = T4_STROBES * (T4_MAX_GAP + 1) + 8;
  localparam int T5_STROBES  = 8;
  localparam int T5_MIN_GAP  = 20;
  localparam int T5_MAX_GAP  = 40;
  localparam int T5_CYCLES   = T5_STROBES * (T5_MAX_GAP + 1) + 8;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                + T4_CYCLES + T5_CYCLES + 20;

  logic     clk;
  logic     i_rst;
  logic     i_req_valid;
  req_mat_t i_request;
  logic     o_grant_valid;
  gnt_mat_t o_out_grant;
  req_mat_t o_in_grant;

  // Reference model state, one pointer per arbiter
  int in_ptr [N];
  int out_ptr [M];

  // Expected results in strobe order
  gnt_mat_t exp_out_q [$];
  req_mat_t exp_in_q [$];
  int       exp_cyc_q [$];  // Cycle of each strobe

  int          cyc         = 0;
  int          error_count = 0;
  int          check_count = 0;
  int          grant_count = 0;

  always #5 clk = ~clk;  // 10 ns period

  switch_alloc_top dut_i (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_req_valid  (i_req_valid),
    .i_request    (i_request),
    .o_grant_valid(o_grant_valid),
    .o_out_grant  (o_out_grant),
    .o_in_grant   (o_in_grant)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // Input stage picks, then each output keeps one picker
  task automatic model_allocate(input req_mat_t req, output gnt_mat_t og,
                                output req_mat_t ig);
    int pick [N];
    int cand;
    int win;
    og = '0;
    ig = '0;
    for (int i = 0; i < N; i++) begin
      pick[i] = -1;
      for (int k = 0; k < M; k++) begin
        cand = (in_ptr[i] + k) % M;  // Upward from pointer, wrapping
        if (pick[i] < 0 && req[i][cand]) begin
          pick[i] = cand;
        end
      end
      if (pick[i] >= 0) begin
        in_ptr[i] = (pick[i] + 1) % M;  // Moves even if output stage refuses
      end
    end
    for (int o = 0; o < M; o++) begin
      win = -1;
      for (int k = 0; k < N; k++) begin
        cand = (out_ptr[o] + k) % N;
        if (win < 0 && pick[cand] == o) begin
          win = cand;
        end
      end
      if (win >= 0) begin
        out_ptr[o]  = (win + 1) % N;
        og[o][win]  = 1'b1;
        ig[win][o]  = 1'b1;
      end
    end
  endtask

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  function automatic req_mat_t random_req();
    logic [31:0]   rnd;
    logic [NM-1:0] flat;
    rnd  = $urandom;
    flat = rnd[NM-1:0];
    return flat;
  endfunction

  // One strobe, expected result queued right away
  task automatic send_req(input req_mat_t req);
    gnt_mat_t og;
    req_mat_t ig;
    @(negedge clk);
    i_req_valid = 1'b1;
    i_request   = req;
    model_allocate(req, og, ig);
    exp_out_q.push_back(og);
    exp_in_q.push_back(ig);
    exp_cyc_q.push_back(cyc);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      i_req_valid = 1'b0;
      i_request   = '0;
    end
  endtask

  // Wait out every outstanding result
  task automatic drain();
    idle_cycles(1);
    while (exp_out_q.size() > 0) begin
      idle_cycles(1);
    end
    idle_cycles(2);
  endtask

  task automatic report_test(input string name, input int err0, input int chk0);
    $display("test %-18s finished: %0d checks, %0d errors", name,
             check_count - chk0, error_count - err0);
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  task automatic test_idle_single();
    int err0;
    int chk0;
    int grants0;
    err0 = error_count;
    chk0 = check_count;
    for (int c = 0; c < 10; c++) begin
      idle_cycles(1);
      check_count++;
      if (o_grant_valid !== 1'b0) begin
        $display("mismatch o_grant_valid: got %h expected %h", o_grant_valid, 1'b0);
        error_count++;
      end
    end
    grants0 = grant_count;
    send_req(random_req());
    idle_cycles(6);
    check_count++;
    if (grant_count - grants0 != 1) begin
      $display("one request gave %0d grant strobes instead of one", grant_count - grants0);
      error_count++;
    end
    drain();
    report_test("idle_then_single", err0, chk0);
  endtask

  // Permutation of outputs, so no two inputs collide
  // Each result is read two edges after its own strobe
  task automatic test_single_input();
    int       err0;
    int       chk0;
    int       perm [M];
    int       sw;
    int       tmp;
    req_mat_t req;
    err0 = error_count;
    chk0 = check_count;
    for (int r = 0; r < T2_ROUNDS; r++) begin
      for (int k = 0; k < M; k++) begin
        perm[k] = k;
      end
      for (int k = M - 1; k > 0; k--) begin
        sw       = $urandom_range(k, 0);
        tmp      = perm[k];
        perm[k]  = perm[sw];
        perm[sw] = tmp;
      end
      req = '0;
      for (int i = 0; i < N && i < M; i++) begin
        req[i][perm[i]] = 1'b1;
      end
      send_req(req);
      idle_cycles(2);
      check_count++;
      if (o_grant_valid !== 1'b1) begin
        $display("mismatch o_grant_valid: got %h expected %h", o_grant_valid, 1'b1);
        error_count++;
      end else if (o_in_grant !== req) begin
        $display("mismatch o_in_grant: got %h expected %h", o_in_grant, req);
        error_count++;
      end
    end
    drain();
    report_test("single_input", err0, chk0);
  endtask

  // Every input wants the same output, winner rotates
  task automatic test_contention();
    int       err0;
    int       chk0;
    int       tgt;
    int       first;
    req_mat_t req;
    out_req_t col;
    err0  = error_count;
    chk0  = check_count;
    tgt   = $urandom_range(M - 1, 0);
    first = out_ptr[tgt];
    req   = '0;
    for (int i = 0; i < N; i++) begin
      req[i][tgt] = 1'b1;
    end
    for (int r = 0; r < T3_ROUNDS; r++) begin
      send_req(req);
      idle_cycles(2);  // Result due on this edge
      col = '0;
      col[(first + r) % N] = 1'b1;
      check_count++;
      if (o_grant_valid !== 1'b1) begin
        $display("mismatch o_grant_valid: got %h expected %h", o_grant_valid, 1'b1);
        error_count++;
      end else if (o_out_grant[tgt] !== col) begin
        $display("mismatch o_out_grant[%0d]: got %h expected %h", tgt,
                 o_out_grant[tgt], col);
        error_count++;
      end
    end
    drain();
    report_test("output_contention", err0, chk0);
  endtask

  task automatic test_random();
    int err0;
    int chk0;
    err0 = error_count;
    chk0 = check_count;
    for (int s = 0; s < T4_STROBES; s++) begin
      send_req(random_req());
      idle_cycles($urandom_range(T4_MAX_GAP, 0));  // Gap 0 gives back to back
    end
    drain();
    report_test("random_matrix", err0, chk0);
  endtask

  // Long idle gaps must leave every pointer alone
  task automatic test_pointer_hold();
    int err0;
    int chk0;
    err0 = error_count;
    chk0 = check_count;
    for (int s = 0; s < T5_STROBES; s++) begin
      send_req(random_req() | random_req());  // Denser rows
      idle_cycles($urandom_range(T5_MAX_GAP, T5_MIN_GAP));
    end
    drain();
    report_test("pointer_hold", err0, chk0);
  endtask

  // --------------------------------------------------
  // Output monitor, sampled on the falling edge
  // --------------------------------------------------

  always @(negedge clk) begin : monitor
    gnt_mat_t exp_out;
    req_mat_t exp_in;
    int       exp_cyc;
    if (!i_rst) begin
      if (o_grant_valid) begin
        grant_count++;
        if (exp_out_q.size() == 0) begin
          $display("grant valid at cycle %0d with no request outstanding", cyc);
          error_count++;
        end else begin
          exp_out = exp_out_q.pop_front();
          exp_in  = exp_in_q.pop_front();
          exp_cyc = exp_cyc_q.pop_front();
          check_count++;
          if (o_out_grant !== exp_out) begin
            $display("mismatch o_out_grant: got %h expected %h", o_out_grant, exp_out);
            error_count++;
          end
          if (o_in_grant !== exp_in) begin
            $display("mismatch o_in_grant: got %h expected %h", o_in_grant, exp_in);
            error_count++;
          end
          if (cyc - exp_cyc != 2) begin
            $display("grant came %0d cycles after its request instead of 2", cyc - exp_cyc);
            error_count++;
          end
        end
      end else begin
        if (o_out_grant !== '0) begin
          $display("mismatch o_out_grant: got %h expected %h", o_out_grant, 0);
          error_count++;
        end
        if (o_in_grant !== '0) begin
          $display("mismatch o_in_grant: got %h expected %h", o_in_grant, 0);
          error_count++;
        end
      end
    end
  end

  // Cycle count and watchdog
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", cyc);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    void'($urandom(SEED));
    clk         = 1'b0;
    i_rst       = 1'b1;
    i_req_valid = 1'b0;
    i_request   = '0;
    for (int i = 0; i < N; i++) begin
      in_ptr[i] = 0;
    end
    for (int o = 0; o < M; o++) begin
      out_ptr[o] = 0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    i_rst = 1'b0;

    test_idle_single();
    test_single_input();
    test_contention();
    test_random();
    test_pointer_hold();

    $display("summary: %0d checks, %0d grants, %0d errors",
             check_count, grant_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/alloc_pkg.sv
hdl/rr_arbiter.sv
hdl/input_first_allocator.sv
hdl/switch_alloc_top.sv
dv/switch_alloc_props.sv
dv/switch_alloc_tb.sv

// ==== Makefile ====
# Verilator build and run of the switch allocator testbench
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= switch_alloc_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= TEST RESULT: PASS

.PHONY: sim clean

# Build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)
